//--- Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_cmd_seq
FILELIST   := compile.f
BUILD_DIR  := obj_dir
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the pass message appears as a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+design
design/cmd_seq_pkg.sv
design/cmd_seq_regs.sv
design/cmd_seq_mem.sv
design/cmd_seq_ctrl.sv
design/cmd_seq_serializer.sv
design/cmd_seq_top.sv
verification/tb_cmd_seq.sv

//--- design/cmd_seq_config.svh
`ifndef CMD_SEQ_CONFIG_SVH
`define CMD_SEQ_CONFIG_SVH

// bus address limit of the command memory, bytes start at address 16
`define CMD_MEM_SIZE 2048

// register file occupies bus addresses 0 .. CMD_REG_COUNT-1
`define CMD_REG_COUNT 16

// address widths
`define CMD_BUS_AW 16
`define CMD_MEM_AW 11

`endif

//--- design/cmd_seq_ctrl.sv
`include "cmd_seq_config.svh"

module cmd_seq_ctrl (
    input  logic                     CMD_CLK_IN,
    input  logic                     seq_rst,
    input  cmd_seq_pkg::cmd_conf_t   conf,
    input  logic                     start_req,
    input  logic                     ext_start,
    output logic [`CMD_MEM_AW-1:0]   mem_rd_addr,
    output cmd_seq_pkg::seq_state_t  state,
    output logic [15:0]              bit_cnt,
    output logic                     load,
    output logic                     cmd_start_flag,
    output logic                     cmd_ready
);

    import cmd_seq_pkg::*;

    seq_state_t  next_state;
    logic        send_cmd;
    logic [31:0] rep_cnt;
    logic        end_rep;      // last bit of a repeated section
    logic        end_rep_next;
    logic        pass_end;
    logic        more_passes;
    logic [15:0] rep_end_bit;  // counter value one before the section end
    logic [15:0] next_idx;     // bit index needed in the next cycle

    assign send_cmd    = start_req | ext_start;
    assign rep_end_bit = conf.cmd_size - 16'd1 - conf.stop_repeat;
    assign more_passes = (conf.repeat_count == 32'd0) || (rep_cnt < conf.repeat_count);
    assign pass_end    = (bit_cnt == conf.cmd_size) || end_rep;

    always_comb begin
        case (state)
            SEQ_WAIT: next_state = send_cmd ? SEQ_SEND : SEQ_WAIT;
            SEQ_SEND: begin
                if (bit_cnt == conf.cmd_size && rep_cnt == conf.repeat_count) begin
                    next_state = SEQ_WAIT;
                end else begin
                    next_state = SEQ_SEND;
                end
            end
            default: next_state = SEQ_WAIT;
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            state <= SEQ_WAIT;
        end else begin
            state <= next_state;
        end
    end

    // flag the section end one cycle early
    assign end_rep_next = (state == SEQ_SEND) && more_passes &&
                          (bit_cnt == rep_end_bit) && !end_rep;

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            end_rep <= 1'b0;
        end else begin
            end_rep <= end_rep_next;
        end
    end

    // counter runs 1..S while a bit is on the line, 0 while idle
    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst || state != SEQ_SEND || next_state != SEQ_SEND) begin
            bit_cnt <= 16'd0;
        end else if (pass_end) begin
            bit_cnt <= conf.start_repeat + 16'd1; // later passes resume at A
        end else begin
            bit_cnt <= bit_cnt + 16'd1;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst || send_cmd) begin
            rep_cnt <= 32'd1;
        end else if (state == SEQ_SEND && pass_end && rep_cnt != 32'hffff_ffff) begin
            rep_cnt <= rep_cnt + 32'd1; // saturates for endless mode
        end
    end

    always_comb begin
        if (state == SEQ_WAIT) begin
            next_idx = 16'd0;
        end else if (bit_cnt == conf.cmd_size - 16'd1 || end_rep_next) begin
            next_idx = conf.start_repeat;
        end else if (end_rep) begin
            next_idx = conf.start_repeat + 16'd1;
        end else begin
            next_idx = bit_cnt + 16'd1;
        end
    end

    assign mem_rd_addr = next_idx[`CMD_MEM_AW+2:3]; // byte of the bit

    // take a new byte on byte boundaries and pass restarts
    assign load = (state == SEQ_SEND) && (next_state == SEQ_SEND) &&
                  (pass_end || bit_cnt[2:0] == 3'd0);

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            cmd_start_flag <= 1'b0;
            cmd_ready      <= 1'b1;
        end else begin
            cmd_start_flag <= (state == SEQ_SEND) && (bit_cnt == 16'd1) && !conf.dis_cmd_pulse;
            cmd_ready      <= (state == SEQ_WAIT);
        end
    end

endmodule

//--- design/cmd_seq_mem.sv
`include "cmd_seq_config.svh"

module cmd_seq_mem (
    input  logic                   CMD_CLK_IN,
    input  logic [`CMD_BUS_AW-1:0] bus_add,
    input  logic [7:0]             bus_data_in,
    input  logic                   bus_wr,
    input  logic [`CMD_MEM_AW-1:0] mem_rd_addr,
    output logic [7:0]             mem_rd_byte,
    output logic [7:0]             mem_rd_data
);

    logic [7:0]             cmd_mem [0:`CMD_MEM_SIZE-1];
    logic [`CMD_BUS_AW-1:0] bus_offset;
    logic [`CMD_MEM_AW-1:0] bus_mem_addr;
    logic                   bus_in_mem;

    // command bytes start after the register file
    assign bus_offset   = bus_add - `CMD_BUS_AW'(`CMD_REG_COUNT);
    assign bus_mem_addr = bus_offset[`CMD_MEM_AW-1:0];
    assign bus_in_mem   = (bus_add >= `CMD_REG_COUNT) && (bus_add < `CMD_MEM_SIZE);

    always_ff @(posedge CMD_CLK_IN) begin
        if (bus_wr && bus_in_mem) begin
            cmd_mem[bus_mem_addr] <= bus_data_in;
        end
    end

    // bus readback port
    always_ff @(posedge CMD_CLK_IN) begin
        mem_rd_byte <= cmd_mem[bus_mem_addr];
    end

    // sequencer port, address issued one cycle ahead
    always_ff @(posedge CMD_CLK_IN) begin
        mem_rd_data <= cmd_mem[mem_rd_addr];
    end

endmodule

//--- design/cmd_seq_pkg.sv
package cmd_seq_pkg;

    // line code of the serial output
    typedef enum logic [1:0] {
        MODE_POS          = 2'd0, // bit on rising edge
        MODE_NEG          = 2'd1, // bit delayed half a cycle
        MODE_MANCH_IEEE   = 2'd2, // IEEE 802.3 manchester
        MODE_MANCH_THOMAS = 2'd3  // thomas manchester, biphase-L
    } out_mode_t;

    typedef enum logic {
        SEQ_WAIT = 1'b0,
        SEQ_SEND = 1'b1
    } seq_state_t;

    // sequence configuration as decoded from the register bytes
    typedef struct packed {
        logic        dis_cmd_pulse;  // byte 2 bit 4
        logic        dis_clock_gate; // byte 2 bit 3
        out_mode_t   output_mode;    // byte 2 bits 2:1
        logic        en_ext_start;   // byte 2 bit 0
        logic [15:0] cmd_size;       // bytes 4:3, pattern length in bits
        logic [31:0] repeat_count;   // bytes 8:5, 0 = endless
        logic [15:0] start_repeat;   // bytes 10:9
        logic [15:0] stop_repeat;    // bytes 12:11
    } cmd_conf_t;

endpackage

//--- design/cmd_seq_regs.sv
`include "cmd_seq_config.svh"

module cmd_seq_regs (
    input  logic                     CMD_CLK_IN,
    input  logic                     RST_CMD_CLK,
    input  logic [`CMD_BUS_AW-1:0]   bus_add,
    input  logic [7:0]               bus_data_in,
    input  logic                     bus_wr,
    input  logic                     cmd_ready,
    input  logic [7:0]               mem_rd_byte,
    output logic [7:0]               bus_data_out,
    output cmd_seq_pkg::cmd_conf_t   conf,
    output logic                     seq_rst,
    output logic                     start_req
);

    import cmd_seq_pkg::*;

    localparam int REG_AW = $clog2(`CMD_REG_COUNT);

    logic [7:0]        regs_q [0:`CMD_REG_COUNT-1];
    logic              soft_rst_q;
    logic              rd_is_mem_q; // readback comes from the memory port
    logic [7:0]        rd_hold_q;
    logic [7:0]        rd_next;
    logic [REG_AW-1:0] reg_idx;

    assign reg_idx = bus_add[REG_AW-1:0];

    // write to address 0, cleared one cycle later
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            soft_rst_q <= 1'b0;
        end else begin
            soft_rst_q <= bus_wr && (bus_add == '0);
        end
    end

    assign seq_rst = RST_CMD_CLK | soft_rst_q;

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            start_req <= 1'b0;
        end else begin
            start_req <= bus_wr && (bus_add == 'd1);
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            for (int i = 0; i < `CMD_REG_COUNT; i++) begin
                regs_q[i] <= 8'h00;
            end
            regs_q[5] <= 8'd1; // one pass by default
        end else if (bus_wr && (bus_add < `CMD_REG_COUNT)) begin
            regs_q[reg_idx] <= bus_data_in;
        end
    end

    always_comb begin
        conf.dis_cmd_pulse  = regs_q[2][4];
        conf.dis_clock_gate = regs_q[2][3];
        conf.output_mode    = out_mode_t'(regs_q[2][2:1]);
        conf.en_ext_start   = regs_q[2][0];
        conf.cmd_size       = {regs_q[4], regs_q[3]};
        conf.repeat_count   = {regs_q[8], regs_q[7], regs_q[6], regs_q[5]};
        conf.start_repeat   = {regs_q[10], regs_q[9]};
        conf.stop_repeat    = {regs_q[12], regs_q[11]};
    end

    // register side of the readback
    always_comb begin
        if (bus_add == 'd1) begin
            rd_next = {7'b0, cmd_ready};
        end else if (bus_add < `CMD_REG_COUNT) begin
            rd_next = regs_q[reg_idx];
        end else begin
            rd_next = 8'h00; // memory or beyond
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        rd_hold_q   <= rd_next;
        rd_is_mem_q <= (bus_add >= `CMD_REG_COUNT) && (bus_add < `CMD_MEM_SIZE);
    end

    // memory byte is already registered inside the memory
    assign bus_data_out = rd_is_mem_q ? mem_rd_byte : rd_hold_q;

endmodule

//--- design/cmd_seq_serializer.sv
module cmd_seq_serializer (
    input  logic                    CMD_CLK_IN,
    input  logic                    seq_rst,
    input  cmd_seq_pkg::seq_state_t state,
    input  logic [15:0]             bit_cnt,
    input  logic                    load,
    input  logic [7:0]              mem_rd_data,
    input  cmd_seq_pkg::out_mode_t  output_mode,
    input  logic                    dis_clock_gate,
    output logic                    cmd_data,
    output logic                    cmd_clk_out
);

    import cmd_seq_pkg::*;

    logic [7:0]  send_byte;
    logic [15:0] bit_pos;
    logic [2:0]  bit_sel;
    logic        data_ser;
    logic        data_pos;  // captured on the rising edge
    logic        data_neg;  // same bit half a cycle later
    logic        data_hi;
    logic        data_lo;

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst || state == SEQ_WAIT) begin
            send_byte <= 8'h00;
        end else if (load) begin
            send_byte <= mem_rd_data;
        end
    end

    // msb first, counter is one ahead of the bit index
    assign bit_pos  = bit_cnt - 16'd1;
    assign bit_sel  = 3'd7 - bit_pos[2:0];
    assign data_ser = (state == SEQ_SEND) ? send_byte[bit_sel] : 1'b0;

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            data_pos <= 1'b0;
        end else begin
            data_pos <= data_ser;
        end
    end

    always_ff @(negedge CMD_CLK_IN) begin
        if (seq_rst) begin
            data_neg <= 1'b0;
        end else begin
            data_neg <= data_pos;
        end
    end

    // high phase value, then low phase value
    always_comb begin
        case (output_mode)
            MODE_POS: begin
                data_hi = data_pos;
                data_lo = data_pos;
            end
            MODE_NEG: begin
                data_hi = data_neg;
                data_lo = data_neg;
            end
            MODE_MANCH_IEEE: begin
                data_hi = ~data_pos;
                data_lo = data_pos;
            end
            default: begin // thomas
                data_hi = data_pos;
                data_lo = ~data_pos;
            end
        endcase
    end

    // two-phase output stage
    assign cmd_data    = CMD_CLK_IN ? data_hi : data_lo;
    assign cmd_clk_out = CMD_CLK_IN & ~dis_clock_gate;

endmodule

//--- design/cmd_seq_top.sv
`include "cmd_seq_config.svh"

module cmd_seq_top (
    input  logic                   CMD_CLK_IN,
    input  logic                   RST_CMD_CLK,
    input  logic [`CMD_BUS_AW-1:0] bus_add,
    input  logic [7:0]             bus_data_in,
    input  logic                   bus_wr,
    input  logic                   bus_rd,      // reads have no side effect
    input  logic                   cmd_ext_start_flag,
    output logic [7:0]             bus_data_out,
    output logic                   cmd_clk_out,
    output logic                   cmd_ext_start_enable,
    output logic                   cmd_data,
    output logic                   cmd_ready,
    output logic                   cmd_start_flag
);

    import cmd_seq_pkg::*;

    cmd_conf_t              conf;
    seq_state_t             state;
    logic                   seq_rst;
    logic                   start_req;
    logic                   ext_start;
    logic                   load;
    logic [15:0]            bit_cnt;
    logic [`CMD_MEM_AW-1:0] mem_rd_addr;
    logic [7:0]             mem_rd_data;
    logic [7:0]             mem_rd_byte;

    assign cmd_ext_start_enable = conf.en_ext_start;
    assign ext_start            = cmd_ext_start_flag & conf.en_ext_start;

    cmd_seq_regs cmd_seq_regs_inst (
        .CMD_CLK_IN   (CMD_CLK_IN),
        .RST_CMD_CLK  (RST_CMD_CLK),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .cmd_ready    (cmd_ready),
        .mem_rd_byte  (mem_rd_byte),
        .bus_data_out (bus_data_out),
        .conf         (conf),
        .seq_rst      (seq_rst),
        .start_req    (start_req)
    );

    cmd_seq_mem cmd_seq_mem_inst (
        .CMD_CLK_IN  (CMD_CLK_IN),
        .bus_add     (bus_add),
        .bus_data_in (bus_data_in),
        .bus_wr      (bus_wr),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_byte (mem_rd_byte),
        .mem_rd_data (mem_rd_data)
    );

    cmd_seq_ctrl cmd_seq_ctrl_inst (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .seq_rst        (seq_rst),
        .conf           (conf),
        .start_req      (start_req),
        .ext_start      (ext_start),
        .mem_rd_addr    (mem_rd_addr),
        .state          (state),
        .bit_cnt        (bit_cnt),
        .load           (load),
        .cmd_start_flag (cmd_start_flag),
        .cmd_ready      (cmd_ready)
    );

    cmd_seq_serializer cmd_seq_serializer_inst (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .seq_rst        (seq_rst),
        .state          (state),
        .bit_cnt        (bit_cnt),
        .load           (load),
        .mem_rd_data    (mem_rd_data),
        .output_mode    (conf.output_mode),
        .dis_clock_gate (conf.dis_clock_gate),
        .cmd_data       (cmd_data),
        .cmd_clk_out    (cmd_clk_out)
    );

endmodule

//--- verification/tb_cmd_seq.sv
`include "cmd_seq_config.svh"

module tb_cmd_seq;

    localparam int MAX_BYTES = `CMD_MEM_SIZE - `CMD_REG_COUNT;

    logic        CMD_CLK_IN;
    logic        RST_CMD_CLK;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic        cmd_ext_start_flag;
    logic [7:0]  bus_data_out;
    logic        cmd_clk_out;
    logic        cmd_ext_start_enable;
    logic        cmd_data;
    logic        cmd_ready;
    logic        cmd_start_flag;

    logic [31:0] lfsr = 32'h767c84ac;
    logic [7:0]  mem_model [0:MAX_BYTES-1]; // command bytes as written
    logic [7:0]  reg_vals [0:`CMD_REG_COUNT-1];
    bit          exp_bits [$];
    int          mem_addrs [$];
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          flag_count;
    int          cycle_cnt;
    int          limit_cycles = 4000; // bus traffic margin, sequences add to it

    // values seen by the last sample_cycle call
    logic        hi_now;
    logic        lo_now;
    logic        flag_now;
    logic        ready_now;
    logic        clk_now;

    cmd_seq_top cmd_seq_top_inst (
        .CMD_CLK_IN           (CMD_CLK_IN),
        .RST_CMD_CLK          (RST_CMD_CLK),
        .bus_add              (bus_add),
        .bus_data_in          (bus_data_in),
        .bus_wr               (bus_wr),
        .bus_rd               (bus_rd),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .bus_data_out         (bus_data_out),
        .cmd_clk_out          (cmd_clk_out),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .cmd_data             (cmd_data),
        .cmd_ready            (cmd_ready),
        .cmd_start_flag       (cmd_start_flag)
    );

    always #50 CMD_CLK_IN = ~CMD_CLK_IN;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000; // galois taps
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge CMD_CLK_IN);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge CMD_CLK_IN);
        bus_wr <= 1'b0;
    endtask

    // data is registered, valid one cycle after the address
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge CMD_CLK_IN);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge CMD_CLK_IN);
        bus_rd <= 1'b0;
        #25;
        data = bus_data_out;
    endtask

    task automatic pulse_ext_start();
        @(posedge CMD_CLK_IN);
        cmd_ext_start_flag <= 1'b1;
        @(posedge CMD_CLK_IN);
        cmd_ext_start_flag <= 1'b0;
    endtask

    // one value in each clock phase
    task automatic sample_cycle();
        @(posedge CMD_CLK_IN);
        #25;
        hi_now    = cmd_data;
        flag_now  = cmd_start_flag;
        ready_now = cmd_ready;
        clk_now   = cmd_clk_out;
        if (cmd_start_flag) begin
            flag_count++;
        end
        @(negedge CMD_CLK_IN);
        #25;
        lo_now = cmd_data;
    endtask

    task automatic wait_ready(input logic level, input int max_cycles, input string what);
        int waited;
        waited = 0;
        sample_cycle();
        while (ready_now !== level && waited < max_cycles) begin
            sample_cycle();
            waited++;
        end
        if (ready_now !== level) begin
            $display("%s: cmd_ready did not go to %0b within %0d cycles", what, level, max_cycles);
            errors++;
        end
    endtask

    task automatic load_pattern(input int nbits);
        for (int k = 0; k < (nbits + 7) / 8; k++) begin
            mem_model[k] = 8'(rand_bits(8));
            bus_write(16'(`CMD_REG_COUNT + k), mem_model[k]);
        end
    endtask

    task automatic set_config(input logic [7:0] ctrl, input int size, input int reps,
                              input int first, input int stop);
        bus_write(16'd2, ctrl);
        bus_write(16'd3, size[7:0]);
        bus_write(16'd4, size[15:8]);
        for (int i = 0; i < 4; i++) begin
            bus_write(16'(5 + i), reps[8*i +: 8]);
        end
        bus_write(16'd9, first[7:0]);
        bus_write(16'd10, first[15:8]);
        bus_write(16'd11, stop[7:0]);
        bus_write(16'd12, stop[15:8]);
    endtask

    // pass 1 from bit 0, later passes from first, all but the last end at size-1-stop
    task automatic build_expected(input int size, input int reps, input int first, input int stop);
        int         lo_bit;
        int         hi_bit;
        logic [7:0] byte_v;
        exp_bits.delete();
        for (int p = 1; p <= reps; p++) begin
            lo_bit = (p == 1) ? 0 : first;
            hi_bit = (p == reps) ? size - 1 : size - 1 - stop;
            for (int i = lo_bit; i <= hi_bit; i++) begin
                byte_v = mem_model[i / 8];
                exp_bits.push_back(byte_v[3'(7 - i % 8)]); // msb first
            end
        end
    endtask

    task automatic run_seq(input string name, input logic [7:0] ctrl, input int size,
                           input int reps, input int first, input int stop, input bit use_ext);
        int         n;
        int         waited;
        int         exp_pulses;
        bit         e;
        bit         e_prev;
        logic [1:0] exp_pair;
        build_expected(size, reps, first, stop);
        n = exp_bits.size();
        exp_bits.push_back(1'b0); // line back at zero after the last bit
        exp_pulses = (first == 0) ? reps : 1; // every pass that begins at bit 0
        limit_cycles += 4 * n;
        set_config(ctrl, size, reps, first, stop);
        flag_count = 0;
        if (use_ext) begin
            pulse_ext_start();
        end else begin
            bus_write(16'd1, 8'h00);
        end
        waited = 0;
        sample_cycle();
        while (!flag_now && waited < 20) begin
            sample_cycle();
            waited++;
        end
        if (!flag_now) begin
            $display("%s: no start pulse within 20 cycles of the start", name);
            errors++;
        end else begin
            check({name, " ready low"}, 0, 32'(ready_now));
            e_prev = 1'b0;
            for (int i = 0; i <= n; i++) begin
                if (i > 0) begin
                    sample_cycle();
                end
                e = exp_bits[i];
                case (ctrl[2:1])
                    2'd0:    exp_pair = {e, e};
                    2'd1:    exp_pair = {e_prev, e}; // half a cycle late
                    2'd2:    exp_pair = {~e, e};
                    default: exp_pair = {e, ~e};
                endcase
                check($sformatf("%s bit %0d", name, i), 32'(exp_pair), 32'({hi_now, lo_now}));
                e_prev = e;
            end
            wait_ready(1'b1, 10, name);
            check({name, " start pulses"}, exp_pulses, flag_count);
        end
    endtask

    initial begin
        while (cycle_cnt <= limit_cycles) begin
            @(posedge CMD_CLK_IN);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", limit_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int         k;
        int         size;
        int         first;
        int         stop;
        int         reps;
        int         low_cycles;
        logic [7:0] rd;
        logic [31:0] reps_rd;
        CMD_CLK_IN         = 1'b0;
        RST_CMD_CLK        = 1'b1;
        bus_add            = '0;
        bus_data_in        = '0;
        bus_wr             = 1'b0;
        bus_rd             = 1'b0;
        cmd_ext_start_flag = 1'b0;
        errors             = 0;
        errors_at_start    = 0;
        tests_run          = 0;
        tests_failed       = 0;
        repeat (2) @(posedge CMD_CLK_IN);
        RST_CMD_CLK <= 1'b0;

        // register file and memory readback
        for (int r = 2; r < `CMD_REG_COUNT; r++) begin
            reg_vals[r] = 8'(rand_bits(8));
            bus_write(16'(r), reg_vals[r]);
        end
        for (int r = 2; r < `CMD_REG_COUNT; r++) begin
            bus_read(16'(r), rd);
            check($sformatf("regs_mem reg %0d", r), 32'(reg_vals[r]), 32'(rd));
        end
        for (int j = 0; j < 24; j++) begin
            k = int'(rand_bits(11)) % MAX_BYTES;
            mem_addrs.push_back(k);
            mem_model[k] = 8'(rand_bits(8));
            bus_write(16'(`CMD_REG_COUNT + k), mem_model[k]);
        end
        foreach (mem_addrs[j]) begin
            bus_read(16'(`CMD_REG_COUNT + mem_addrs[j]), rd);
            check($sformatf("regs_mem mem %0d", mem_addrs[j]),
                  32'(mem_model[mem_addrs[j]]), 32'(rd));
        end
        bus_read(16'd1, rd);
        check("regs_mem ready", 1, 32'(rd));
        bus_read(16'(`CMD_MEM_SIZE), rd);
        check("regs_mem beyond", 0, 32'(rd));
        bus_read(16'(`CMD_MEM_SIZE + rand_bits(12)), rd);
        check("regs_mem beyond", 0, 32'(rd));
        bus_read(16'hffff, rd);
        check("regs_mem beyond", 0, 32'(rd));
        end_test("regs_mem");

        size = 8 + int'(rand_bits(6));
        load_pattern(size);
        run_seq("single_pass", 8'h00, size, 1, 0, 0, 1'b0);
        end_test("single_pass");

        // first and stop kept small so every pass reaches its end bit
        size  = 24 + int'(rand_bits(5));
        first = int'(rand_bits(3));
        stop  = int'(rand_bits(3));
        reps  = 2 + int'(rand_bits(2)) % 3;
        load_pattern(size);
        run_seq("repeat_section", 8'h00, size, reps, first, stop, 1'b0);
        end_test("repeat_section");

        size = 16 + int'(rand_bits(5));
        load_pattern(size);
        run_seq("line_codes mode 0", 8'h00, size, 1, 0, 0, 1'b0);
        run_seq("line_codes mode 1", 8'h02, size, 1, 0, 0, 1'b0);
        run_seq("line_codes mode 2", 8'h04, size, 1, 0, 0, 1'b0);
        run_seq("line_codes mode 3", 8'h06, size, 1, 0, 0, 1'b0);
        end_test("line_codes");

        size = 8 + int'(rand_bits(4));
        load_pattern(size);
        set_config(8'h00, size, 1, 0, 0);
        check("ext_start_gating enable off", 0, 32'(cmd_ext_start_enable));
        pulse_ext_start();
        low_cycles = 0;
        repeat (10) begin
            sample_cycle();
            if (!ready_now) begin
                low_cycles++;
            end
        end
        check("ext_start_gating ignored start", 0, low_cycles);
        run_seq("ext_start_gating ext", 8'h01, size, 1, 0, 0, 1'b1);
        check("ext_start_gating enable on", 1, 32'(cmd_ext_start_enable));
        set_config(8'h10, size, 1, 0, 0); // start pulse suppressed
        flag_count = 0;
        bus_write(16'd1, 8'h00);
        wait_ready(1'b0, 10, "ext_start_gating busy");
        wait_ready(1'b1, size + 10, "ext_start_gating idle");
        check("ext_start_gating start pulses", 0, flag_count);
        bus_write(16'd2, 8'h08);
        repeat (4) begin
            sample_cycle();
            check("ext_start_gating gated clock", 0, 32'(clk_now));
        end
        bus_write(16'd2, 8'h00);
        sample_cycle();
        check("ext_start_gating free clock", 1, 32'(clk_now));
        end_test("ext_start_gating");

        // endless sequence, only a soft reset stops it
        size  = 16 + int'(rand_bits(5));
        first = int'(rand_bits(3));
        stop  = int'(rand_bits(3));
        load_pattern(size);
        limit_cycles += 4 * 3 * size;
        set_config(8'h00, size, 0, first, stop);
        bus_write(16'd1, 8'h00);
        wait_ready(1'b0, 10, "soft_reset start");
        repeat (3 * size) sample_cycle();
        check("soft_reset still busy", 0, 32'(ready_now));
        bus_write(16'd0, 8'h5a);
        wait_ready(1'b1, 10, "soft_reset");
        reps_rd = '0;
        for (int i = 0; i < 4; i++) begin
            bus_read(16'(5 + i), rd);
            reps_rd[8*i +: 8] = rd;
        end
        check("soft_reset repeat count", 1, reps_rd);
        end_test("soft_reset");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
